// File: common/fcb_consts.svh
`ifndef FCB_CONSTS_SVH
`define FCB_CONSTS_SVH

// Register map, word addresses
`define FCB_ADDR_CTRL   3'd0
`define FCB_ADDR_DATA   3'd1
`define FCB_ADDR_LEN    3'd2
`define FCB_ADDR_CHK    3'd3
`define FCB_ADDR_STATUS 3'd4
`define FCB_ADDR_RDBK   3'd5

// Fabric geometry
`define FCB_NUM_TILES   8
`define FCB_TILE_BITS   32

// Largest prime below 2**16
`define FCB_ADLER_MOD   65521

`endif

// File: common/fcb_pkg.sv
`default_nettype none

package fcb_pkg;

    // Slave side of the bus, one request per cycle
    typedef struct packed {
        logic [2:0]  address;
        logic [31:0] data;
        logic [3:0]  select;
        logic        stb;
        logic        we;
        logic        cyc;
    } wb_req_t;

    typedef struct packed {
        logic [29:0] reserved;
        logic        readback_en;
        logic        program_en;   // Bit 0
    } fcb_ctrl_t;

    // Control word as stored and read back, or as decoded fields
    typedef union packed {
        logic [31:0] raw;
        fcb_ctrl_t   fields;
    } fcb_ctrl_u;

    typedef struct packed {
        logic [26:0] reserved;
        logic        overrun;
        logic        checksum_mismatch;
        logic        checksum_match;
        logic        bitstream_done;
        logic        word_done;    // Bit 0
    } fcb_status_t;

    // One link of the configuration chain
    // cfg_bit carries the data bit, since "bit" is a keyword
    typedef struct packed {
        logic cfg_bit;
        logic shift;
    } chain_t;

endpackage

`default_nettype wire

// File: hdl/fcb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcb_consts.svh"

module fcb_regs (
    input  wire                    clk,
    input  wire                    reset,
    input  fcb_pkg::wb_req_t       bus,
    output logic [31:0]            rd_data,
    output fcb_pkg::fcb_ctrl_u     ctrl,
    output logic [31:0]            length,
    output logic [31:0]            expected,
    output logic [31:0]            data_word,
    output logic                   data_wr,
    input  wire                    word_done_p,
    input  wire                    done_p,
    input  wire                    match_p,
    input  wire                    mismatch_p,
    input  wire                    overrun_p,
    input  wire [31:0]             rdbk_word,
    output logic                   bitstream_done
);

    fcb_pkg::fcb_status_t status;
    logic                 wr_en;
    logic                 prog_q;
    logic                 rb_q;
    logic                 prog_rise;
    logic                 rb_rise;

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_val,
                                                input logic [31:0] new_val,
                                                input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i])
                res[8*i +: 8] = new_val[8*i +: 8];
        end
        return res;
    endfunction

    assign wr_en          = bus.stb & bus.we & bus.cyc;
    assign prog_rise      = ctrl.fields.program_en & ~prog_q;
    assign rb_rise        = ctrl.fields.readback_en & ~rb_q;
    assign bitstream_done = status.bitstream_done;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ctrl.raw <= '0;
            length   <= '0;
            expected <= '0;
            data_wr  <= 1'b0;
            status   <= '0;
            prog_q   <= 1'b0;
            rb_q     <= 1'b0;
        end else begin
            prog_q  <= ctrl.fields.program_en;
            rb_q    <= ctrl.fields.readback_en;
            data_wr <= wr_en && (bus.address == `FCB_ADDR_DATA);
            if (wr_en) begin
                case (bus.address)
                    `FCB_ADDR_CTRL: ctrl.raw <= merge_bytes(ctrl.raw, bus.data, bus.select);
                    `FCB_ADDR_LEN:  length   <= merge_bytes(length, bus.data, bus.select);
                    `FCB_ADDR_CHK:  expected <= merge_bytes(expected, bus.data, bus.select);
                    default: ;
                endcase
            end

            // Sticky bits, set wins over clear
            if (word_done_p)
                status.word_done <= 1'b1;
            else if (prog_rise || data_wr)
                status.word_done <= 1'b0;   // Rearmed by each new data word
            if (done_p)
                status.bitstream_done <= 1'b1;
            else if (prog_rise)
                status.bitstream_done <= 1'b0;
            if (match_p)
                status.checksum_match <= 1'b1;
            else if (prog_rise || rb_rise)
                status.checksum_match <= 1'b0;
            if (mismatch_p)
                status.checksum_mismatch <= 1'b1;
            else if (prog_rise || rb_rise)
                status.checksum_mismatch <= 1'b0;
            if (overrun_p)
                status.overrun <= 1'b1;
            else if (prog_rise)
                status.overrun <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (bus.address == `FCB_ADDR_DATA))
            data_word <= merge_bytes(data_word, bus.data, bus.select);
    end

    always_comb begin
        rd_data = '0;
        if (bus.stb && !bus.we) begin
            case (bus.address)
                `FCB_ADDR_CTRL:   rd_data = ctrl.raw;
                `FCB_ADDR_DATA:   rd_data = data_word;
                `FCB_ADDR_LEN:    rd_data = length;
                `FCB_ADDR_CHK:    rd_data = expected;
                `FCB_ADDR_STATUS: rd_data = status;
                `FCB_ADDR_RDBK:   rd_data = rdbk_word;
                default:          rd_data = '0;
            endcase
        end
    end

    // Shifter may only finish a bitstream while programming is enabled
    a_done_needs_prog: assert property (@(posedge clk) disable iff (!reset)
        done_p |-> ctrl.fields.program_en);

endmodule

`default_nettype wire

// File: hdl/config_tile.sv
`timescale 1ns/1ps
`default_nettype none

module config_tile #(
    parameter int TILE_BITS = 32
) (
    input  wire                  clk,
    input  wire                  reset,
    input  fcb_pkg::chain_t      chain_in,
    input  wire                  load,
    output fcb_pkg::chain_t      chain_out,
    output logic [TILE_BITS-1:0] config_bits
);

    logic [TILE_BITS-1:0] cells;

    // Oldest bit sits in the top cell
    always_ff @(posedge clk) begin
        if (chain_in.shift)
            cells <= {cells[TILE_BITS-2:0], chain_in.cfg_bit};
    end

    assign chain_out.cfg_bit = cells[TILE_BITS-1];
    assign chain_out.shift   = chain_in.shift;   // Same strobe down the chain

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            config_bits <= '0;
        else if (load)
            config_bits <= cells;   // Shadow copy drives the fabric
    end

endmodule

`default_nettype wire

// File: fcb/bitstream_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module bitstream_shifter (
    input  wire                 clk,
    input  wire                 reset,
    input  fcb_pkg::fcb_ctrl_u  ctrl,
    input  wire [31:0]          data_word,
    input  wire [31:0]          length,
    input  wire                 data_wr,
    input  wire                 recirc_bit,
    input  wire                 recirc_shift,
    output fcb_pkg::chain_t     head,
    output logic                load,
    output logic                word_done_p,
    output logic                done_p,
    output logic                overrun_p
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_DONE
    } state_t;

    state_t      state;
    logic [31:0] shift_word;
    logic [5:0]  word_cnt;
    logic [31:0] total_cnt;
    logic        prog_q;
    logic        prog_rise;
    logic        start;
    logic        shift_now;
    logic        shift_bit;
    logic        last_bit;
    logic        word_end;

    always_comb begin
        prog_rise = ctrl.fields.program_en & ~prog_q;
        start     = data_wr & ctrl.fields.program_en & (state == S_IDLE);
        shift_now = start | (state == S_SHIFT);
        shift_bit = start ? data_word[31] : shift_word[31];   // MSB leads
        last_bit  = (total_cnt + 32'd1) == length;
        word_end  = word_cnt == 6'd31;
        if (state == S_DONE) begin
            head.cfg_bit = recirc_bit;   // Readback loops tail to head
            head.shift   = recirc_shift;
        end else begin
            head.cfg_bit = shift_bit;
            head.shift   = shift_now;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state       <= S_IDLE;
            word_cnt    <= '0;
            total_cnt   <= '0;
            prog_q      <= 1'b0;
            load        <= 1'b0;
            word_done_p <= 1'b0;
            done_p      <= 1'b0;
            overrun_p   <= 1'b0;
        end else begin
            prog_q      <= ctrl.fields.program_en;
            word_done_p <= shift_now & (word_end | last_bit);
            done_p      <= shift_now & last_bit;
            load        <= shift_now & last_bit;
            overrun_p   <= data_wr & (state == S_SHIFT);   // Word dropped
            if (shift_now) begin
                total_cnt <= total_cnt + 32'd1;
                word_cnt  <= (word_end || last_bit) ? 6'd0 : word_cnt + 6'd1;
            end
            case (state)
                S_IDLE: begin
                    if (prog_rise)
                        total_cnt <= '0;
                    else if (start)
                        state <= last_bit ? S_DONE : S_SHIFT;
                end
                S_SHIFT: begin
                    if (last_bit)
                        state <= S_DONE;
                    else if (word_end)
                        state <= S_IDLE;
                end
                S_DONE: begin
                    if (prog_rise) begin   // New bitstream
                        state     <= S_IDLE;
                        total_cnt <= '0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            shift_word <= {data_word[30:0], 1'b0};
        else if (state == S_SHIFT)
            shift_word <= shift_word << 1;
    end

    // Programming and readback never drive the chain together
    a_one_chain_driver: assert property (@(posedge clk) disable iff (!reset)
        !(shift_now && recirc_shift));

endmodule

`default_nettype wire

// File: fcb/readback_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcb_consts.svh"

module readback_checker (
    input  wire                 clk,
    input  wire                 reset,
    input  fcb_pkg::fcb_ctrl_u  ctrl,
    input  wire                 bitstream_done,
    input  wire [31:0]          length,
    input  wire [31:0]          expected,
    input  wire                 tail,
    output logic                recirc_bit,
    output logic                recirc_shift,
    output logic [31:0]         rdbk_word,
    output logic                match_p,
    output logic                mismatch_p
);

    logic        running;
    logic        rb_q;
    logic        rb_start;
    logic        last;
    logic [31:0] cnt;
    logic [2:0]  bit_idx;
    logic [6:0]  byte_sr;
    logic [7:0]  byte_q;
    logic        byte_vld;
    logic [15:0] sum_a;
    logic [15:0] sum_b;
    logic [16:0] a_sum;
    logic [16:0] a_red;
    logic [17:0] b_sum;
    logic [17:0] b_red;
    logic [2:0]  fin;
    logic [31:0] result_q;

    assign recirc_bit   = tail;
    assign recirc_shift = running;

    always_comb begin
        rb_start = ctrl.fields.readback_en & ~rb_q & bitstream_done & ~running & (length != 0);
        last     = cnt == (length - 32'd1);
        a_sum    = {1'b0, sum_a} + {9'd0, byte_q};
        a_red    = (a_sum >= 17'(`FCB_ADLER_MOD)) ? a_sum - 17'(`FCB_ADLER_MOD) : a_sum;
        b_sum    = {2'b00, sum_b} + {1'b0, a_red};
        b_red    = (b_sum >= 18'(`FCB_ADLER_MOD)) ? b_sum - 18'(`FCB_ADLER_MOD) : b_sum;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            running    <= 1'b0;
            rb_q       <= 1'b0;
            cnt        <= '0;
            bit_idx    <= '0;
            byte_vld   <= 1'b0;
            sum_a      <= 16'd1;
            sum_b      <= '0;
            fin        <= '0;
            match_p    <= 1'b0;
            mismatch_p <= 1'b0;
        end else begin
            rb_q     <= ctrl.fields.readback_en;
            byte_vld <= running & ((bit_idx == 3'd7) | last);
            fin      <= {fin[1:0], running & last};
            if (rb_start) begin
                running <= 1'b1;
                cnt     <= '0;
                bit_idx <= '0;
                sum_a   <= 16'd1;
                sum_b   <= '0;
            end else if (running) begin
                cnt     <= cnt + 32'd1;
                bit_idx <= bit_idx + 3'd1;
                if (last)
                    running <= 1'b0;
            end
            if (byte_vld) begin
                sum_a <= a_red[15:0];
                sum_b <= b_red[15:0];
            end
            match_p    <= fin[2] & (result_q == expected);
            mismatch_p <= fin[2] & (result_q != expected);
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            rdbk_word <= {rdbk_word[30:0], tail};
            byte_sr   <= {byte_sr[5:0], tail};
            // Short last byte is left aligned, zero padded
            if (bit_idx == 3'd7 || last)
                byte_q <= {byte_sr, tail} << (3'd7 - bit_idx);
        end
        if (fin[1])
            result_q <= {sum_b, sum_a};
    end

    a_sum_a_reduced: assert property (@(posedge clk) disable iff (!reset)
        sum_a < 16'(`FCB_ADLER_MOD));

endmodule

`default_nettype wire

// File: hdl/fcb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcb_consts.svh"

module fcb_top (
    input  wire                                       clk,
    input  wire                                       reset,
    input  fcb_pkg::wb_req_t                          bus,
    output logic [31:0]                               rd_data,
    output logic [`FCB_NUM_TILES*`FCB_TILE_BITS-1:0]  config_bits,
    output logic                                      global_reset
);

    fcb_pkg::fcb_ctrl_u ctrl;
    fcb_pkg::chain_t    chain [0:`FCB_NUM_TILES];
    logic [31:0]        length;
    logic [31:0]        expected;
    logic [31:0]        data_word;
    logic [31:0]        rdbk_word;
    logic               data_wr;
    logic               word_done_p;
    logic               done_p;
    logic               match_p;
    logic               mismatch_p;
    logic               overrun_p;
    logic               bitstream_done;
    logic               load;
    logic               recirc_bit;
    logic               recirc_shift;

    fcb_regs i_regs (
        .clk            (clk),
        .reset          (reset),
        .bus            (bus),
        .rd_data        (rd_data),
        .ctrl           (ctrl),
        .length         (length),
        .expected       (expected),
        .data_word      (data_word),
        .data_wr        (data_wr),
        .word_done_p    (word_done_p),
        .done_p         (done_p),
        .match_p        (match_p),
        .mismatch_p     (mismatch_p),
        .overrun_p      (overrun_p),
        .rdbk_word      (rdbk_word),
        .bitstream_done (bitstream_done)
    );

    bitstream_shifter i_shifter (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .data_word    (data_word),
        .length       (length),
        .data_wr      (data_wr),
        .recirc_bit   (recirc_bit),
        .recirc_shift (recirc_shift),
        .head         (chain[0]),
        .load         (load),
        .word_done_p  (word_done_p),
        .done_p       (done_p),
        .overrun_p    (overrun_p)
    );

    // Last tile holds the first bits, so it lands on top
    for (genvar k = 0; k < `FCB_NUM_TILES; k++) begin : g_tile
        config_tile #(
            .TILE_BITS (`FCB_TILE_BITS)
        ) i_tile (
            .clk         (clk),
            .reset       (reset),
            .chain_in    (chain[k]),
            .load        (load),
            .chain_out   (chain[k+1]),
            .config_bits (config_bits[k*`FCB_TILE_BITS +: `FCB_TILE_BITS])
        );
    end

    readback_checker i_checker (
        .clk            (clk),
        .reset          (reset),
        .ctrl           (ctrl),
        .bitstream_done (bitstream_done),
        .length         (length),
        .expected       (expected),
        .tail           (chain[`FCB_NUM_TILES].cfg_bit),
        .recirc_bit     (recirc_bit),
        .recirc_shift   (recirc_shift),
        .rdbk_word      (rdbk_word),
        .match_p        (match_p),
        .mismatch_p     (mismatch_p)
    );

    assign global_reset = bitstream_done;   // Fabric held in reset until configured

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b0;   // Active low from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
    end

    always #2 clk = ~clk;   // 4 ns period

endmodule

`default_nettype wire

// File: testbench/fcb_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fcb_consts.svh"

module fcb_tb;

    localparam int CHAIN_BITS  = `FCB_NUM_TILES * `FCB_TILE_BITS;
    localparam int NUM_WORDS   = CHAIN_BITS / 32;
    localparam int CYCLE_LIMIT = 4000;
    localparam int POLL_LIMIT  = 600;

    localparam logic [31:0] ST_WORD_DONE = 32'h01;
    localparam logic [31:0] ST_BS_DONE   = 32'h02;
    localparam logic [31:0] ST_MATCH     = 32'h04;
    localparam logic [31:0] ST_MISMATCH  = 32'h08;
    localparam logic [31:0] ST_OVERRUN   = 32'h10;

    logic                  clk;
    logic                  reset;
    fcb_pkg::wb_req_t      bus;
    logic [31:0]           rd_data;
    logic [CHAIN_BITS-1:0] config_bits;
    logic                  global_reset;

    logic [31:0]           lfsr_state;
    logic [31:0]           last_word;
    logic [CHAIN_BITS-1:0] config_model;   // Words in write order, first on top
    int                    mismatch_count;
    int                    failure_count;
    int                    cycle_count = 0;

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    fcb_top i_dut (
        .clk          (clk),
        .reset        (reset),
        .bus          (bus),
        .rd_data      (rd_data),
        .config_bits  (config_bits),
        .global_reset (global_reset)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        failure_count++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // Bytes taken MSB first from the top of the chain image
    function automatic logic [31:0] adler32_ref(input logic [CHAIN_BITS-1:0] bits);
        int unsigned a;
        int unsigned b;
        a = 1;
        b = 0;
        for (int i = 0; i < CHAIN_BITS / 8; i++) begin
            a = (a + 32'(bits[CHAIN_BITS-1-8*i -: 8])) % `FCB_ADLER_MOD;
            b = (b + a) % `FCB_ADLER_MOD;
        end
        return {b[15:0], a[15:0]};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic bus_write(input logic [2:0] addr, input logic [31:0] data,
                             input logic [3:0] sel);
        @(negedge clk);
        bus.address = addr;
        bus.data    = data;
        bus.select  = sel;
        bus.stb     = 1'b1;
        bus.we      = 1'b1;
        bus.cyc     = 1'b1;
        @(negedge clk);
        bus = '0;
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [31:0] data);
        @(negedge clk);
        bus         = '0;
        bus.address = addr;
        bus.stb     = 1'b1;
        bus.cyc     = 1'b1;
        #1;
        data = rd_data;
    endtask

    task automatic expect_read(input logic [2:0] addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] rd;
        bus_read(addr, rd);
        if (rd !== exp)
            report_mismatch($sformatf("%s read %h, expected %h", what, rd, exp));
    endtask

    task automatic wait_status(input logic [31:0] mask, input string what);
        logic [31:0] st;
        int          polls;
        polls = 0;
        bus_read(`FCB_ADDR_STATUS, st);
        while ((st & mask) == 32'h0 && polls < POLL_LIMIT) begin
            bus_read(`FCB_ADDR_STATUS, st);
            polls++;
        end
        if ((st & mask) == 32'h0)
            report_failure($sformatf("status never showed %s", what));
    endtask

    task automatic send_word(input logic [31:0] w);
        bus_write(`FCB_ADDR_DATA, w, 4'hf);
        config_model = {config_model[CHAIN_BITS-33:0], w};
        last_word    = w;
    endtask

    task automatic wait_word_done();
        wait_cycles(2);   // Old flag clears after the data strobe
        wait_status(ST_WORD_DONE, "word_done");
    endtask

    task automatic check_config(input string what);
        if (global_reset !== 1'b1)
            report_mismatch($sformatf("%s: global_reset is %b, expected 1", what, global_reset));
        if (config_bits !== config_model)
            report_mismatch($sformatf("%s: config_bits %h, expected %h",
                                      what, config_bits, config_model));
    endtask

    task automatic test_register_access();
        if (global_reset !== 1'b0)
            report_mismatch($sformatf("global_reset after reset is %b, expected 0",
                                      global_reset));
        if (config_bits !== '0)
            report_mismatch($sformatf("config_bits after reset %h, expected 0",
                                      config_bits));
        expect_read(`FCB_ADDR_STATUS, 32'h0, "status after reset");
        bus_write(`FCB_ADDR_CTRL, 32'ha5a5_a500, 4'b1010);
        bus_write(`FCB_ADDR_CTRL, 32'h005a_0000, 4'b0100);
        bus_write(`FCB_ADDR_LEN, 32'h1234_5678, 4'b1111);
        bus_write(`FCB_ADDR_LEN, 32'hffff_ffff, 4'b0001);
        bus_write(`FCB_ADDR_CHK, 32'hdead_beef, 4'b0011);
        bus_write(`FCB_ADDR_CHK, 32'hcafe_0000, 4'b1100);
        expect_read(`FCB_ADDR_CTRL, 32'ha55a_a500, "control");
        expect_read(`FCB_ADDR_LEN, 32'h1234_56ff, "length");
        expect_read(`FCB_ADDR_CHK, 32'hcafe_beef, "checksum");
        expect_read(3'd6, 32'h0, "unmapped address 6");
        expect_read(3'd7, 32'h0, "unmapped address 7");
        expect_read(`FCB_ADDR_STATUS, 32'h0, "status after register writes");
    endtask

    task automatic test_full_programming();
        logic [31:0] w;
        bus_write(`FCB_ADDR_LEN, 32'(CHAIN_BITS), 4'hf);
        bus_write(`FCB_ADDR_CTRL, 32'h1, 4'hf);
        config_model = '0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            take_random_word(w);
            send_word(w);
            wait_word_done();
        end
        wait_status(ST_BS_DONE, "bitstream_done");
        expect_read(`FCB_ADDR_STATUS, ST_WORD_DONE | ST_BS_DONE, "status after programming");
        check_config("full programming");
    endtask

    task automatic test_overrun();
        logic [31:0] w;
        bus_write(`FCB_ADDR_CTRL, 32'h0, 4'h1);
        bus_write(`FCB_ADDR_CTRL, 32'h1, 4'h1);   // Restart clears the sticky bits
        config_model = '0;
        take_random_word(w);
        send_word(w);
        take_random_word(w);
        bus_write(`FCB_ADDR_DATA, w, 4'hf);   // Lands mid-shift, dropped
        wait_word_done();
        for (int i = 1; i < NUM_WORDS; i++) begin
            take_random_word(w);
            send_word(w);
            wait_word_done();
        end
        wait_status(ST_BS_DONE, "bitstream_done");
        expect_read(`FCB_ADDR_STATUS, ST_WORD_DONE | ST_BS_DONE | ST_OVERRUN,
                    "status after overrun");
        check_config("overrun");
    endtask

    task automatic test_readback_match();
        bus_write(`FCB_ADDR_CHK, adler32_ref(config_model), 4'hf);
        bus_write(`FCB_ADDR_CTRL, 32'h3, 4'h1);
        wait_cycles(2);
        wait_status(ST_MATCH | ST_MISMATCH, "a checksum result");
        expect_read(`FCB_ADDR_STATUS, ST_WORD_DONE | ST_BS_DONE | ST_MATCH | ST_OVERRUN,
                    "status after matching readback");
        expect_read(`FCB_ADDR_RDBK, last_word, "readback word");
        check_config("readback match");
    endtask

    task automatic test_readback_mismatch();
        bus_write(`FCB_ADDR_CHK, adler32_ref(config_model) ^ 32'h1, 4'hf);
        bus_write(`FCB_ADDR_CTRL, 32'h1, 4'h1);
        bus_write(`FCB_ADDR_CTRL, 32'h3, 4'h1);
        wait_cycles(2);   // Lets the rising readback_en clear the old result
        wait_status(ST_MATCH | ST_MISMATCH, "a checksum result");
        expect_read(`FCB_ADDR_STATUS, ST_WORD_DONE | ST_BS_DONE | ST_MISMATCH | ST_OVERRUN,
                    "status after failing readback");
        // Second pass only sees the last word again if the first pass recirculated
        expect_read(`FCB_ADDR_RDBK, last_word, "readback word after second pass");
        check_config("readback mismatch");
    endtask

    initial begin
        bus            = '0;
        lfsr_state     = 32'h2c24e1a8;
        last_word      = '0;
        config_model   = '0;
        mismatch_count = 0;
        failure_count  = 0;
        @(posedge reset);
        test_register_access();
        test_full_programming();
        test_overrun();
        test_readback_match();
        test_readback_mismatch();
        wait_cycles(4);
        $display("Error counts: %0d value mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/fcb_pkg.sv
hdl/fcb_regs.sv
hdl/config_tile.sv
fcb/bitstream_shifter.sv
fcb/readback_checker.sv
hdl/fcb_top.sv
testbench/tb_clock.sv
testbench/fcb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then scan the log for the failure line
verilator --binary --timing --assert --top-module fcb_tb -f vlog.f -o fcb_sim \
    && ./obj_dir/fcb_sim > sim.log 2>&1 \
    && ! grep -q "tests failed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
